// ==== Bender.yml ====
package:
  name: cps_game

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/cps_mem_pkg.sv
      - mem/rom_client_slot.sv
      - mem/bank_arbiter.sv
      - src/cps_game_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/cps_game_sva.sv
      - test/cps_game_tb.sv

// ==== common/cps_mem_cfg.svh ====
/* Widths and region codes of the ROM data path.
   Each region code selects a 1M-word slice of the flat SDRAM word space. */
`ifndef CPS_MEM_CFG_SVH
`define CPS_MEM_CFG_SVH

// Every ROM word is one 16-bit SDRAM word
`define CPS_DATA_W      16

// Client offset inside its own region
`define CPS_OFFSET_W    20

// Sound CPU sees a smaller ROM
`define CPS_SND_ADDR_W  16

// Region field sits above the offset
`define CPS_REGION_W    2

`define CPS_NUM_CLIENTS 3

// Region codes double as client indices in req/fill vectors
`define CPS_REGION_MAIN 0
`define CPS_REGION_SND  1
`define CPS_REGION_GFX  2

`endif

// ==== common/cps_mem_pkg.sv ====
/* Data and address types of the ROM data path.
   The SDRAM address is region above offset, 22 bits in total. */
`default_nettype none

`include "cps_mem_cfg.svh"

package cps_mem_pkg;

    localparam int SDRAM_ADDR_W = `CPS_REGION_W + `CPS_OFFSET_W;

    // One ROM data word
    typedef logic [`CPS_DATA_W-1:0] rom_data_t;

    // Offset inside a client region
    typedef logic [`CPS_OFFSET_W-1:0] rom_offset_t;

    // SDRAM word address
    // flat is what the SDRAM port sees,
    // split is how the arbiter places a client region
    typedef union packed {
        logic [SDRAM_ADDR_W-1:0] flat;
        struct packed {
            logic [`CPS_REGION_W-1:0] region;
            rom_offset_t              offset;
        } split;
    } sdram_addr_u;

endpackage

`default_nettype wire

// ==== mem/bank_arbiter.sv ====
/* Fixed-priority arbiter for one SDRAM read bank with gfx first, then main, then sound.
   One read in flight at a time. ba_rdy may come with ba_ack or any time after. */
`default_nettype none

`include "cps_mem_cfg.svh"

module bank_arbiter (
    input  logic                         VB,
    input  logic                         arst_n,
    input  logic [`CPS_NUM_CLIENTS-1:0]  req,
    input  cps_mem_pkg::rom_offset_t     main_req_addr,
    input  cps_mem_pkg::rom_offset_t     snd_req_addr,
    input  cps_mem_pkg::rom_offset_t     gfx_req_addr,
    output logic [`CPS_NUM_CLIENTS-1:0]  fill,
    output cps_mem_pkg::rom_data_t       fill_data,
    output cps_mem_pkg::sdram_addr_u     ba_addr,
    output logic                         ba_rd,
    input  logic                         ba_ack,
    input  logic                         ba_rdy,
    input  cps_mem_pkg::rom_data_t       data_read
);

    import cps_mem_pkg::*;

    localparam logic [1:0] ST_IDLE     = 2'd0;
    localparam logic [1:0] ST_WAIT_ACK = 2'd1;
    localparam logic [1:0] ST_WAIT_RDY = 2'd2;

    logic [1:0]                  state;
    logic [`CPS_NUM_CLIENTS-1:0] grant;
    logic [`CPS_NUM_CLIENTS-1:0] pick;
    sdram_addr_u                 pick_addr;
    logic                        start;
    logic                        done;

    // Priority pick and region placement
    always_comb begin
        pick      = '0;
        pick_addr = '0;
        if (req[`CPS_REGION_GFX]) begin
            pick[`CPS_REGION_GFX]  = 1'b1;
            pick_addr.split.region = `CPS_REGION_W'(`CPS_REGION_GFX);
            pick_addr.split.offset = gfx_req_addr;
        end else if (req[`CPS_REGION_MAIN]) begin
            pick[`CPS_REGION_MAIN] = 1'b1;
            pick_addr.split.region = `CPS_REGION_W'(`CPS_REGION_MAIN);
            pick_addr.split.offset = main_req_addr;
        end else if (req[`CPS_REGION_SND]) begin
            pick[`CPS_REGION_SND]  = 1'b1;
            pick_addr.split.region = `CPS_REGION_W'(`CPS_REGION_SND);
            pick_addr.split.offset = snd_req_addr;
        end
    end

    // The served slot still shows req during its fill cycle, so wait it out
    assign start = (state == ST_IDLE) && (|req) && !(|fill);

    // Read data is back, possibly in the same cycle as the ack
    assign done = ba_rdy && ((state == ST_WAIT_RDY) ||
                             ((state == ST_WAIT_ACK) && ba_ack));

    always_ff @(posedge VB or negedge arst_n) begin
        if (!arst_n) begin
            state <= ST_IDLE;
            grant <= '0;
            fill  <= '0;
        end else begin
            fill <= '0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_WAIT_ACK;
                        grant <= pick;
                    end
                end
                ST_WAIT_ACK: begin
                    if (done) begin
                        state <= ST_IDLE;
                        fill  <= grant;
                    end else if (ba_ack) begin
                        state <= ST_WAIT_RDY;
                    end
                end
                ST_WAIT_RDY: begin
                    if (done) begin
                        state <= ST_IDLE;
                        fill  <= grant;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Address held for the whole access, data held for the fill pulse
    always_ff @(posedge VB) begin
        if (start) begin
            ba_addr <= pick_addr;
        end
        if (done) begin
            fill_data <= data_read;
        end
    end

    assign ba_rd = (state == ST_WAIT_ACK);

endmodule

`default_nettype wire

// ==== mem/rom_client_slot.sv ====
/* One-entry read cache in front of the shared SDRAM port.
   cs and addr must hold until ok. A new address seen while a request is
   pending is fetched only after the current fill. */
`default_nettype none

module rom_client_slot (
    input  logic                     VB,
    input  logic                     arst_n,
    input  logic                     cs,
    input  cps_mem_pkg::rom_offset_t addr,
    output cps_mem_pkg::rom_data_t   data,
    output logic                     ok,
    output logic                     req,
    output cps_mem_pkg::rom_offset_t req_addr,
    input  logic                     fill,
    input  cps_mem_pkg::rom_data_t   fill_data
);

    import cps_mem_pkg::*;

    rom_offset_t cached_addr;
    rom_data_t   cached_data;
    logic        cached_valid;
    logic        hit;
    logic        miss;
    logic        fill_hit;
    logic        ok_q;

    // Presented address against the cache entry
    assign hit = cached_valid && (addr == cached_addr);

    // Only start a new fetch when nothing is in flight
    assign miss = cs && !hit && !req;

    // Incoming fill belongs to the address on the port right now
    assign fill_hit = fill && (addr == req_addr);

    always_ff @(posedge VB or negedge arst_n) begin
        if (!arst_n) begin
            req          <= 1'b0;
            cached_valid <= 1'b0;
            ok_q         <= 1'b0;
        end else begin
            ok_q <= cs && (hit || fill_hit);
            if (fill) begin
                req          <= 1'b0;
                cached_valid <= 1'b1;
            end else if (miss) begin
                req <= 1'b1;
            end
        end
    end

    // Address and data of the cache entry
    always_ff @(posedge VB) begin
        if (fill) begin
            cached_addr <= req_addr;
            cached_data <= fill_data;
        end
        if (miss) begin
            req_addr <= addr;
        end
    end

    assign data = cached_data;

    // Drops at once when cs falls or the address moves off the entry
    assign ok = ok_q && cs && hit;

endmodule

`default_nettype wire

// ==== src/cps_game_top.sv ====
/* ROM read path of the game board: three cs/ok clients on one SDRAM bank.
   Regions are main at 0, sound at 1M words, gfx at 2M words. */
`default_nettype none

`include "cps_mem_cfg.svh"

module cps_game_top (
    input  logic                        VB,
    input  logic                        arst_n,
    // Main CPU ROM
    input  logic                        main_cs,
    input  cps_mem_pkg::rom_offset_t    main_addr,
    output cps_mem_pkg::rom_data_t      main_data,
    output logic                        main_ok,
    // Sound CPU ROM
    input  logic                        snd_cs,
    input  logic [`CPS_SND_ADDR_W-1:0]  snd_addr,
    output cps_mem_pkg::rom_data_t      snd_data,
    output logic                        snd_ok,
    // Graphics ROM
    input  logic                        gfx_cs,
    input  cps_mem_pkg::rom_offset_t    gfx_addr,
    output cps_mem_pkg::rom_data_t      gfx_data,
    output logic                        gfx_ok,
    // SDRAM bank read port
    output cps_mem_pkg::sdram_addr_u    ba_addr,
    output logic                        ba_rd,
    input  logic                        ba_ack,
    input  logic                        ba_rdy,
    input  cps_mem_pkg::rom_data_t      data_read
);

    import cps_mem_pkg::*;

    logic [`CPS_NUM_CLIENTS-1:0] req;
    logic [`CPS_NUM_CLIENTS-1:0] fill;
    rom_data_t                   fill_data;
    rom_offset_t                 main_req_addr;
    rom_offset_t                 snd_req_addr;
    rom_offset_t                 gfx_req_addr;
    rom_offset_t                 snd_offset;

    // Sound ROM sits at the bottom of its region
    assign snd_offset = {{(`CPS_OFFSET_W-`CPS_SND_ADDR_W){1'b0}}, snd_addr};

    rom_client_slot u_main_slot (
        .VB        ( VB                      ),
        .arst_n    ( arst_n                  ),
        .cs        ( main_cs                 ),
        .addr      ( main_addr               ),
        .data      ( main_data               ),
        .ok        ( main_ok                 ),
        .req       ( req[`CPS_REGION_MAIN]   ),
        .req_addr  ( main_req_addr           ),
        .fill      ( fill[`CPS_REGION_MAIN]  ),
        .fill_data ( fill_data               )
    );

    rom_client_slot u_snd_slot (
        .VB        ( VB                      ),
        .arst_n    ( arst_n                  ),
        .cs        ( snd_cs                  ),
        .addr      ( snd_offset              ),
        .data      ( snd_data                ),
        .ok        ( snd_ok                  ),
        .req       ( req[`CPS_REGION_SND]    ),
        .req_addr  ( snd_req_addr            ),
        .fill      ( fill[`CPS_REGION_SND]   ),
        .fill_data ( fill_data               )
    );

    rom_client_slot u_gfx_slot (
        .VB        ( VB                      ),
        .arst_n    ( arst_n                  ),
        .cs        ( gfx_cs                  ),
        .addr      ( gfx_addr                ),
        .data      ( gfx_data                ),
        .ok        ( gfx_ok                  ),
        .req       ( req[`CPS_REGION_GFX]    ),
        .req_addr  ( gfx_req_addr            ),
        .fill      ( fill[`CPS_REGION_GFX]   ),
        .fill_data ( fill_data               )
    );

    bank_arbiter u_arbiter (
        .VB            ( VB            ),
        .arst_n        ( arst_n        ),
        .req           ( req           ),
        .main_req_addr ( main_req_addr ),
        .snd_req_addr  ( snd_req_addr  ),
        .gfx_req_addr  ( gfx_req_addr  ),
        .fill          ( fill          ),
        .fill_data     ( fill_data     ),
        .ba_addr       ( ba_addr       ),
        .ba_rd         ( ba_rd         ),
        .ba_ack        ( ba_ack        ),
        .ba_rdy        ( ba_rdy        ),
        .data_read     ( data_read     )
    );

endmodule

`default_nettype wire

// ==== test/cps_game_stimulus.txt ====
// client offset hold seed flags, all hex; client 0 main, 1 sound, 2 gfx, f ends the list
// flags 0 drop cs after hold, 1 keep cs and move to the next address, 2 start with next line
0 01234 2 5a3c 0    // single main read
1 0abcd 1 5a3c 0    // sound read, region 1
2 40010 0 c0de 2    // three clients in the same cycle
0 00200 0 c0de 2
1 0f00f 0 c0de 0
0 00200 3 c0de 0    // repeat of the cached main address
2 40010 1 c0de 0    // repeat of the cached gfx address
0 00300 2 1357 1    // main moves its address with cs held
0 00304 1 1357 0
1 0f00f 0 1357 0    // sound cache still holds the older word
2 7ffff 2 9e37 1
2 00001 0 9e37 0
0 fffff 0 2468 0
f 00000 0 0000 0

// ==== test/cps_game_sva.sv ====
/* SDRAM handshake and client ok checks, bound into cps_game_top.
   All checks are off while arst_n is low. */
`default_nettype none

module cps_game_sva (
    input logic                     VB,
    input logic                     arst_n,
    input logic                     ba_rd,
    input logic                     ba_ack,
    input cps_mem_pkg::sdram_addr_u ba_addr,
    input logic                     main_cs,
    input logic                     main_ok,
    input logic                     snd_cs,
    input logic                     snd_ok,
    input logic                     gfx_cs,
    input logic                     gfx_ok
);

    // Read request holds until the SDRAM takes it
    rd_held: assert property (@(posedge VB) disable iff (!arst_n)
        ba_rd && !ba_ack |=> ba_rd)
        else $error("ba_rd dropped before ba_ack");

    addr_stable: assert property (@(posedge VB) disable iff (!arst_n)
        ba_rd && !ba_ack |=> $stable(ba_addr))
        else $error("ba_addr moved while waiting for ba_ack");

    main_ok_cs: assert property (@(posedge VB) disable iff (!arst_n) main_ok |-> main_cs)
        else $error("main_ok high without main_cs");

    snd_ok_cs: assert property (@(posedge VB) disable iff (!arst_n) snd_ok |-> snd_cs)
        else $error("snd_ok high without snd_cs");

    gfx_ok_cs: assert property (@(posedge VB) disable iff (!arst_n) gfx_ok |-> gfx_cs)
        else $error("gfx_ok high without gfx_cs");

endmodule

bind cps_game_top cps_game_sva sva_i (.*);

`default_nettype wire

// ==== test/cps_game_tb.sv ====
/* Testbench for the ROM read path, with an SDRAM model that delays ack and rdy.
   Requests, hold times and data seeds come from test/cps_game_stimulus.txt. */
`default_nettype none

`include "cps_mem_cfg.svh"

module cps_game_tb;

    import cps_mem_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DRV_DLY    = 5;
    localparam int MAX_LINES  = 64;
    localparam int NC         = `CPS_NUM_CLIENTS;

    logic                       VB;
    logic                       arst_n;
    logic                       main_cs;
    rom_offset_t                main_addr;
    rom_data_t                  main_data;
    logic                       main_ok;
    logic                       snd_cs;
    logic [`CPS_SND_ADDR_W-1:0] snd_addr;
    rom_data_t                  snd_data;
    logic                       snd_ok;
    logic                       gfx_cs;
    rom_offset_t                gfx_addr;
    rom_data_t                  gfx_data;
    logic                       gfx_ok;
    sdram_addr_u                ba_addr;
    logic                       ba_rd;
    logic                       ba_ack;
    logic                       ba_rdy;
    rom_data_t                  data_read;

    // Five words per line with client, offset, hold, seed and flags
    logic [`CPS_OFFSET_W-1:0]   stim [0:5*MAX_LINES-1];
    int                         line_count;
    logic [31:0]                rng;
    rom_data_t                  model_seed;
    sdram_addr_u                fetch_q[$];
    rom_offset_t                last_addr [NC];
    rom_data_t                  last_seed [NC];
    logic                       last_valid [NC];

    cps_game_top dut_i (
        .VB        ( VB        ),
        .arst_n    ( arst_n    ),
        .main_cs   ( main_cs   ),
        .main_addr ( main_addr ),
        .main_data ( main_data ),
        .main_ok   ( main_ok   ),
        .snd_cs    ( snd_cs    ),
        .snd_addr  ( snd_addr  ),
        .snd_data  ( snd_data  ),
        .snd_ok    ( snd_ok    ),
        .gfx_cs    ( gfx_cs    ),
        .gfx_addr  ( gfx_addr  ),
        .gfx_data  ( gfx_data  ),
        .gfx_ok    ( gfx_ok    ),
        .ba_addr   ( ba_addr   ),
        .ba_rd     ( ba_rd     ),
        .ba_ack    ( ba_ack    ),
        .ba_rdy    ( ba_rdy    ),
        .data_read ( data_read )
    );

    initial begin
        VB = 1'b0;
        forever #(CLK_PERIOD / 2) VB = ~VB;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Region code of the client above its offset
    function automatic sdram_addr_u place_in_region(input int client, input rom_offset_t offset);
        sdram_addr_u a;
        a.split.region = client[`CPS_REGION_W-1:0];
        a.split.offset = offset;
        return a;
    endfunction

    function automatic rom_data_t expected_word(input int client, input rom_offset_t offset,
                                                input rom_data_t seed);
        sdram_addr_u a;
        a = place_in_region(client, offset);
        return a.flat[`CPS_DATA_W-1:0] ^ seed;
    endfunction

    // Fetches leave in the order gfx, main, sound
    function automatic int client_by_priority(input int rank);
        case (rank)
            0:       return `CPS_REGION_GFX;
            1:       return `CPS_REGION_MAIN;
            default: return `CPS_REGION_SND;
        endcase
    endfunction

    function automatic string client_name(input int client);
        case (client)
            `CPS_REGION_MAIN: return "main";
            `CPS_REGION_SND:  return "snd";
            default:          return "gfx";
        endcase
    endfunction

    function automatic logic ok_of(input int client);
        case (client)
            `CPS_REGION_MAIN: return main_ok;
            `CPS_REGION_SND:  return snd_ok;
            default:          return gfx_ok;
        endcase
    endfunction

    function automatic rom_data_t data_of(input int client);
        case (client)
            `CPS_REGION_MAIN: return main_data;
            `CPS_REGION_SND:  return snd_data;
            default:          return gfx_data;
        endcase
    endfunction

    task automatic drive_client(input int client, input logic cs, input rom_offset_t addr);
        case (client)
            `CPS_REGION_MAIN: begin
                main_cs   = cs;
                main_addr = addr;
            end
            `CPS_REGION_SND: begin
                snd_cs   = cs;
                snd_addr = addr[`CPS_SND_ADDR_W-1:0];
            end
            default: begin
                gfx_cs   = cs;
                gfx_addr = addr;
            end
        endcase
    endtask

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare_data(input string name, input rom_data_t exp, input rom_data_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic compare_addr(input string name, input sdram_addr_u exp,
                                input sdram_addr_u act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %h actual %h",
                     $time, name, exp.flat, act.flat);
            abort_run();
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t: %s expected %b actual %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    // SDRAM read bank with 0 to 3 cycles to ack and 0 to 3 more to rdy
    initial begin : sdram_model
        int          ack_wait;
        int          rdy_wait;
        int          phase;
        sdram_addr_u read_addr;
        ack_wait = 0;
        rdy_wait = 0;
        phase    = 0;
        forever begin
            @(posedge VB);
            #DRV_DLY;
            ba_ack = 1'b0;
            ba_rdy = 1'b0;
            if (phase == 0 && ba_rd === 1'b1) begin
                if (fetch_q.size() == 0) begin
                    $display("SDRAM read of %h issued while no fetch was due", ba_addr.flat);
                    abort_run();
                end
                read_addr = fetch_q.pop_front();
                compare_addr("ba_addr", read_addr, ba_addr);
                rng      = xorshift32(rng);
                ack_wait = rng % 4;
                rng      = xorshift32(rng);
                rdy_wait = rng % 4;
                phase    = 1;
            end
            if (phase == 1) begin
                if (ack_wait == 0) begin
                    ba_ack = 1'b1;
                    phase  = 2;
                end else begin
                    ack_wait--;
                end
            end
            if (phase == 2) begin
                if (rdy_wait == 0) begin
                    ba_rdy    = 1'b1;
                    data_read = read_addr.flat[`CPS_DATA_W-1:0] ^ model_seed;
                    phase     = 0;
                end else begin
                    rdy_wait--;
                end
            end
        end
    end

    initial begin : watchdog
        @(posedge arst_n);
        repeat (line_count * 40) @(posedge VB);
        $display("Timeout: the run did not finish within %0d cycles", line_count * 40);
        abort_run();
    end

    initial begin : sequencer
        int          first;
        int          last;
        int          c;
        logic        all_ok;
        logic        in_step [NC];
        logic        fetch [NC];
        rom_offset_t line_addr [NC];
        rom_data_t   exp_data [NC];
        arst_n    = 1'b0;
        ba_ack    = 1'b0;
        ba_rdy    = 1'b0;
        data_read = '0;
        rng       = 32'd81195;
        for (c = 0; c < NC; c++) begin
            drive_client(c, 1'b0, '0);
            last_valid[c] = 1'b0;
            last_addr[c]  = '0;
            last_seed[c]  = '0;
        end
        $readmemh("test/cps_game_stimulus.txt", stim);
        while (line_count < MAX_LINES && stim[5*line_count] !== 'hf) begin
            line_count++;
        end
        if (line_count == MAX_LINES) begin
            $display("Stimulus file has no end marker line");
            abort_run();
        end
        repeat (2) @(posedge VB);
        #DRV_DLY;
        arst_n = 1'b1;
        // Quiet port before the first request
        repeat (3) begin
            @(negedge VB);
            compare_flag("ba_rd", 1'b0, ba_rd);
            for (c = 0; c < NC; c++) begin
                compare_flag({client_name(c), "_ok"}, 1'b0, ok_of(c));
            end
        end
        last = -1;
        while (last + 1 < line_count) begin
            first = last + 1;
            last  = first;
            // Flag 2 starts a line together with the next one
            while (stim[5*last+4] == 2 && last + 1 < line_count) begin
                last++;
            end
            model_seed = stim[5*first+3][`CPS_DATA_W-1:0];
            for (c = 0; c < NC; c++) begin
                in_step[c] = 1'b0;
                fetch[c]   = 1'b0;
            end
            for (int rank = 0; rank < NC; rank++) begin
                for (int i = first; i <= last; i++) begin
                    c = stim[5*i];
                    if (c == client_by_priority(rank)) begin
                        in_step[c]   = 1'b1;
                        line_addr[c] = stim[5*i+1];
                        fetch[c]     = !(last_valid[c] && last_addr[c] == line_addr[c]);
                        if (fetch[c]) begin
                            fetch_q.push_back(place_in_region(c, line_addr[c]));
                            last_addr[c]  = line_addr[c];
                            last_seed[c]  = model_seed;
                            last_valid[c] = 1'b1;
                        end
                        exp_data[c] = expected_word(c, last_addr[c], last_seed[c]);
                    end
                end
            end
            @(posedge VB);
            #DRV_DLY;
            for (c = 0; c < NC; c++) begin
                if (in_step[c]) drive_client(c, 1'b1, line_addr[c]);
            end
            @(negedge VB);
            for (c = 0; c < NC; c++) begin
                if (in_step[c] && fetch[c]) begin
                    compare_flag({client_name(c), "_ok"}, 1'b0, ok_of(c));
                end
            end
            all_ok = 1'b0;
            while (!all_ok) begin
                @(negedge VB);
                all_ok = 1'b1;
                for (c = 0; c < NC; c++) begin
                    if (in_step[c] && ok_of(c) !== 1'b1) all_ok = 1'b0;
                end
            end
            for (c = 0; c < NC; c++) begin
                if (in_step[c]) compare_data({client_name(c), "_data"}, exp_data[c], data_of(c));
            end
            if (fetch_q.size() != 0) begin
                $display("A client got ok before its SDRAM read was issued");
                abort_run();
            end
            repeat (stim[5*last+2]) @(posedge VB);
            // Flag 1 keeps cs high so the next line only moves the address
            if (stim[5*last+4] != 1) begin
                @(posedge VB);
                #DRV_DLY;
                for (c = 0; c < NC; c++) begin
                    if (in_step[c]) drive_client(c, 1'b0, line_addr[c]);
                end
                @(negedge VB);
                for (c = 0; c < NC; c++) begin
                    if (in_step[c]) compare_flag({client_name(c), "_ok"}, 1'b0, ok_of(c));
                end
            end
        end
        repeat (4) @(posedge VB);
        if (ba_rd === 1'b0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("SDRAM read still pending after the last request");
            abort_run();
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+common
common/cps_mem_pkg.sv
mem/rom_client_slot.sv
mem/bank_arbiter.sv
src/cps_game_top.sv
test/cps_game_sva.sv
test/cps_game_tb.sv
